/* rtl/fifo_pkg.sv */
package fifo_pkg;

   // flag values while arst_n_i is low
   parameter logic EMPTY_RST = 1'b1;
   parameter logic FULL_RST  = 1'b0;

   // wider of the two port widths
   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   // narrower of the two port widths
   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of wide over narrow, 0 for a symmetric fifo
   function automatic int ratio_log2(input int a, input int b);
      int ratio;
      int n;
      ratio = max_w(a, b) / min_w(a, b);
      n     = 0;
      while ((1 << n) < ratio) begin
         n = n + 1;
      end
      return n;
   endfunction

endpackage

/* rtl/fifo_ctrl.sv */
`timescale 1ns/1ps

module fifo_ctrl #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic            clk_i,
   input  logic            arst_n_i,
   input  logic            w_en_i,
   input  logic            r_en_i,
   output logic            w_en_int_o,
   output logic            r_en_int_o,
   output logic            w_full_o,
   output logic            r_empty_o,
   output logic [ADDR_W:0] level_o
);

   localparam int LOG_R = fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W);

   // level is counted in narrow units
   localparam logic [ADDR_W:0] W_INCR =
      (W_DATA_W > R_DATA_W) ? (ADDR_W + 1)'(1 << LOG_R) : (ADDR_W + 1)'(1);
   localparam logic [ADDR_W:0] R_INCR =
      (R_DATA_W > W_DATA_W) ? (ADDR_W + 1)'(1 << LOG_R) : (ADDR_W + 1)'(1);
   localparam logic [ADDR_W:0] DEPTH = (ADDR_W + 1)'(1 << ADDR_W);

   logic [ADDR_W:0] level_nxt;
   logic            r_empty_nxt;
   logic            w_full_nxt;

   // requests refused on the registered flags
   assign w_en_int_o = w_en_i & ~w_full_o;
   assign r_en_int_o = r_en_i & ~r_empty_o;

   always_comb begin
      unique case ({w_en_int_o, r_en_int_o})
         2'b10:   level_nxt = level_o + W_INCR;
         2'b01:   level_nxt = level_o - R_INCR;
         2'b11:   level_nxt = level_o + W_INCR - R_INCR;
         default: level_nxt = level_o;
      endcase
   end

   // empty while less than one read word is stored
   assign r_empty_nxt = level_nxt < R_INCR;
   // full once one more write word no longer fits
   assign w_full_nxt  = level_nxt > (DEPTH - W_INCR);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level_o   <= '0;
         r_empty_o <= fifo_pkg::EMPTY_RST;
         w_full_o  <= fifo_pkg::FULL_RST;
      end else begin
         level_o   <= level_nxt;
         r_empty_o <= r_empty_nxt;
         w_full_o  <= w_full_nxt;
      end
   end

endmodule

/* rtl/fifo_addr_gen.sv */
`timescale 1ns/1ps

module fifo_addr_gen #(
   parameter int W_ADDR_W = 6,
   parameter int R_ADDR_W = 4
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                w_en_int_i,
   input  logic                r_en_int_i,
   output logic [W_ADDR_W-1:0] w_addr_o,
   output logic [R_ADDR_W-1:0] r_addr_o
);

   // write pointer in write port units, wraps at the depth
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_addr_o <= '0;
      end else if (w_en_int_i) begin
         w_addr_o <= w_addr_o + 1'b1;
      end
   end

   // read pointer in read port units
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_addr_o <= '0;
      end else if (r_en_int_i) begin
         r_addr_o <= r_addr_o + 1'b1;
      end
   end

endmodule

/* rtl/fifo_asym_converter.sv */
`timescale 1ns/1ps

module fifo_asym_converter #(
   parameter  int W_DATA_W   = 8,
   parameter  int R_DATA_W   = 32,
   parameter  int ADDR_W     = 6,
   localparam int MAX_W      = fifo_pkg::max_w(W_DATA_W, R_DATA_W),
   localparam int MIN_W      = fifo_pkg::min_w(W_DATA_W, R_DATA_W),
   localparam int LOG_R      = fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W),
   localparam int RATIO      = 1 << LOG_R,
   localparam int MEM_ADDR_W = ADDR_W - LOG_R,
   localparam int W_ADDR_W   = (W_DATA_W == MAX_W) ? MEM_ADDR_W : ADDR_W,
   localparam int R_ADDR_W   = (R_DATA_W == MAX_W) ? MEM_ADDR_W : ADDR_W
) (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  w_en_i,
   input  logic [  W_ADDR_W-1:0] w_addr_i,
   input  logic [  W_DATA_W-1:0] w_data_i,
   input  logic                  r_en_i,
   input  logic [  R_ADDR_W-1:0] r_addr_i,
   output logic [  R_DATA_W-1:0] r_data_o,
   output logic [     RATIO-1:0] mem_w_en_o,
   output logic [MEM_ADDR_W-1:0] mem_w_addr_o,
   output logic [     MAX_W-1:0] mem_w_data_o,
   output logic                  mem_r_en_o,
   output logic [MEM_ADDR_W-1:0] mem_r_addr_o,
   input  logic [     MAX_W-1:0] mem_r_data_i
);

   // one memory word, seen whole or as narrow lanes (lane 0 is the lsb)
   typedef union packed {
      logic [MAX_W-1:0]            word;
      logic [RATIO-1:0][MIN_W-1:0] lane;
   } mem_word_t;

   if (W_DATA_W < R_DATA_W) begin : g_narrow_wr
      mem_word_t w_word;

      // same byte on every lane, only the addressed lane is enabled
      always_comb begin
         for (int i = 0; i < RATIO; i++) begin
            w_word.lane[i] = w_data_i;
            mem_w_en_o[i]  = w_en_i && (w_addr_i[LOG_R-1:0] == LOG_R'(i));
         end
      end

      assign mem_w_data_o = w_word.word;
      assign mem_w_addr_o = w_addr_i[ADDR_W-1:LOG_R];
   end else begin : g_wide_wr
      assign mem_w_en_o   = {RATIO{w_en_i}};
      assign mem_w_data_o = w_data_i;
      assign mem_w_addr_o = w_addr_i;
   end

   assign mem_r_en_o = r_en_i;

   if (R_DATA_W < W_DATA_W) begin : g_narrow_rd
      logic [LOG_R-1:0] r_lane_sel;
      mem_word_t        r_word;

      // lane select follows the memory read by one cycle
      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            r_lane_sel <= '0;
         end else if (r_en_i) begin
            r_lane_sel <= r_addr_i[LOG_R-1:0];
         end
      end

      assign r_word       = mem_r_data_i;
      assign r_data_o     = r_word.lane[r_lane_sel];
      assign mem_r_addr_o = r_addr_i[ADDR_W-1:LOG_R];
   end else begin : g_wide_rd
      assign r_data_o     = mem_r_data_i;
      assign mem_r_addr_o = r_addr_i;
   end

endmodule

/* rtl/fifo_ram_2p.sv */
`timescale 1ns/1ps

module fifo_ram_2p #(
   parameter int DATA_W = 32,
   parameter int LANES  = 4,
   parameter int ADDR_W = 4
) (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic [ LANES-1:0] w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   // at least one bit per lane
   localparam int LANE_W = fifo_pkg::max_w(DATA_W / LANES, 1);

   logic [LANES-1:0][LANE_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_i) begin
      for (int l = 0; l < LANES; l++) begin
         if (w_en_i[l]) begin
            mem[w_addr_i][l] <= w_data_i[l*LANE_W +: LANE_W];
         end
      end
   end

   // registered read, holds between reads
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_data_o <= '0;
      end else if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* rtl/fifo_sync_top.sv */
`timescale 1ns/1ps

module fifo_sync_top #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,
   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,
   output logic [  ADDR_W:0]   level_o
);

   localparam int MAX_W      = fifo_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int MIN_W      = fifo_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int LOG_R      = fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W);
   localparam int LANES      = MAX_W / MIN_W;
   localparam int MEM_ADDR_W = ADDR_W - LOG_R;
   localparam int W_ADDR_W   = (W_DATA_W == MAX_W) ? MEM_ADDR_W : ADDR_W;
   localparam int R_ADDR_W   = (R_DATA_W == MAX_W) ? MEM_ADDR_W : ADDR_W;

   logic                  w_en_int;
   logic                  r_en_int;
   logic [  W_ADDR_W-1:0] w_addr;
   logic [  R_ADDR_W-1:0] r_addr;
   logic [     LANES-1:0] mem_w_en;
   logic [MEM_ADDR_W-1:0] mem_w_addr;
   logic [     MAX_W-1:0] mem_w_data;
   logic                  mem_r_en;
   logic [MEM_ADDR_W-1:0] mem_r_addr;
   logic [     MAX_W-1:0] mem_r_data;

   fifo_ctrl #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) fifo_ctrl_i (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .w_en_i    (w_en_i),
      .r_en_i    (r_en_i),
      .w_en_int_o(w_en_int),
      .r_en_int_o(r_en_int),
      .w_full_o  (w_full_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   fifo_addr_gen #(
      .W_ADDR_W(W_ADDR_W),
      .R_ADDR_W(R_ADDR_W)
   ) fifo_addr_gen_i (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .w_en_int_i(w_en_int),
      .r_en_int_i(r_en_int),
      .w_addr_o  (w_addr),
      .r_addr_o  (r_addr)
   );

   fifo_asym_converter #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) fifo_asym_converter_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .w_en_i      (w_en_int),
      .w_addr_i    (w_addr),
      .w_data_i    (w_data_i),
      .r_en_i      (r_en_int),
      .r_addr_i    (r_addr),
      .r_data_o    (r_data_o),
      .mem_w_en_o  (mem_w_en),
      .mem_w_addr_o(mem_w_addr),
      .mem_w_data_o(mem_w_data),
      .mem_r_en_o  (mem_r_en),
      .mem_r_addr_o(mem_r_addr),
      .mem_r_data_i(mem_r_data)
   );

   fifo_ram_2p #(
      .DATA_W(MAX_W),
      .LANES (LANES),
      .ADDR_W(MEM_ADDR_W)
   ) fifo_ram_2p_i (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .w_en_i  (mem_w_en),
      .w_addr_i(mem_w_addr),
      .w_data_i(mem_w_data),
      .r_en_i  (mem_r_en),
      .r_addr_i(mem_r_addr),
      .r_data_o(mem_r_data)
   );

endmodule

/* tb/fifo_sync_sva.sv */
`timescale 1ns/1ps

module fifo_sync_sva #(
   parameter int ADDR_W = 6,
   parameter int W_INCR = 1,
   parameter int R_INCR = 4
) (
   input logic            clk_i,
   input logic            arst_n_i,
   input logic            w_en_i,
   input logic            r_en_i,
   input logic            w_full_o,
   input logic            r_empty_o,
   input logic [ADDR_W:0] level_o
);

   localparam logic [ADDR_W:0] DEPTH = (ADDR_W + 1)'(1 << ADDR_W);
   localparam logic [ADDR_W:0] W_STEP = (ADDR_W + 1)'(W_INCR);
   localparam logic [ADDR_W:0] R_STEP = (ADDR_W + 1)'(R_INCR);

   logic w_acc;
   logic r_acc;

   assign w_acc = w_en_i && !w_full_o;
   assign r_acc = r_en_i && !r_empty_o;

   // an empty FIFO looks the same as one just out of reset
   idle_flags_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (level_o == '0) |->
         (r_empty_o == fifo_pkg::EMPTY_RST) && (w_full_o == fifo_pkg::FULL_RST))
      else $error("zero level without the reset flag values");

   flags_excl_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(r_empty_o && w_full_o))
      else $error("empty and full are high together");

   level_max_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      level_o <= DEPTH)
      else $error("level above the FIFO depth");

   // single-sided operations move the level by one port word
   write_level_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (w_acc && !r_acc) |=> level_o == $past(level_o) + W_STEP)
      else $error("accepted write did not raise the level");

   read_level_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (r_acc && !w_acc) |=> level_o == $past(level_o) - R_STEP)
      else $error("accepted read did not lower the level");

endmodule

bind fifo_sync_top fifo_sync_sva #(
   .ADDR_W(ADDR_W)
) fifo_sync_sva_i (
   .clk_i    (clk_i),
   .arst_n_i (arst_n_i),
   .w_en_i   (w_en_i),
   .r_en_i   (r_en_i),
   .w_full_o (w_full_o),
   .r_empty_o(r_empty_o),
   .level_o  (level_o)
);

/* tb/fifo_sync_tb.sv */
`timescale 1ns/1ps

module fifo_sync_tb;

   localparam int W_DATA_W     = 8;
   localparam int R_DATA_W     = 32;
   localparam int ADDR_W       = 6;
   localparam int RESET_CYCLES = 16;
   localparam int WAIT_LIMIT   = 32;

   logic                clk_i;
   logic                arst_n_i;
   logic                w_en_i;
   logic [W_DATA_W-1:0] w_data_i;
   logic                w_full_o;
   logic                r_en_i;
   logic [R_DATA_W-1:0] r_data_o;
   logic                r_empty_o;
   logic [  ADDR_W:0]   level_o;

   // expectations of the record whose last cycle was just sampled
   logic        have_pending;
   int          p_line;
   int          p_empty;
   int          p_full;
   int          p_level;
   int          p_chk;
   logic [31:0] p_rdata;

   fifo_sync_top #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) fifo_sync_top_i (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .w_en_i   (w_en_i),
      .w_data_i (w_data_i),
      .w_full_o (w_full_o),
      .r_en_i   (r_en_i),
      .r_data_o (r_data_o),
      .r_empty_o(r_empty_o),
      .level_o  (level_o)
   );

   always #4 clk_i = ~clk_i;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int rec_line);
      assert (got === exp) else begin
         $display("FAIL %0t ns: %s is %h, expected %h (trace line %0d)",
                  $time, name, got, exp, rec_line);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_pending();
      if (have_pending) begin
         check_value("r_empty_o", 32'(r_empty_o), 32'(p_empty), p_line);
         check_value("w_full_o", 32'(w_full_o), 32'(p_full), p_line);
         check_value("level_o", 32'(level_o), 32'(p_level), p_line);
         if (p_chk != 0) begin
            check_value("r_data_o", r_data_o, p_rdata, p_line);
         end
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      // DUT leaves reset empty with a zero level
      while (r_empty_o !== 1'b1 || w_full_o !== 1'b0 || level_o !== '0) begin
         if (n == WAIT_LIMIT) begin
            abort_run("FIFO did not come out of reset empty");
         end
         @(negedge clk_i);
         n++;
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      // read out whatever the trace left behind
      while (r_empty_o !== 1'b1) begin
         if (n == WAIT_LIMIT) begin
            abort_run("FIFO did not reach empty at the end of the trace");
         end
         @(posedge clk_i);
         r_en_i <= 1'b1;
         @(negedge clk_i);
         n++;
      end
      if (n != 0) begin
         @(posedge clk_i);
         r_en_i <= 1'b0;
      end
   endtask

   initial begin
      string       line;
      int          trace_fd;
      int          line_no;
      int          records;
      int          fields;
      int          cnt;
      int          w_en;
      int          w_data;
      int          r_en;
      int          e_empty;
      int          e_full;
      int          e_level;
      int          e_chk;
      logic [31:0] e_rdata;

      clk_i        = 1'b0;
      arst_n_i     = 1'b0;
      w_en_i       = 1'b0;
      w_data_i     = '0;
      r_en_i       = 1'b0;
      have_pending = 1'b0;
      line_no      = 0;
      records      = 0;

      trace_fd = $fopen("tb/fifo_trace.txt", "r");
      if (trace_fd == 0) begin
         abort_run("could not open the trace file tb/fifo_trace.txt");
      end

      repeat (RESET_CYCLES) @(posedge clk_i);
      arst_n_i <= 1'b1;
      wait_reset_release();

      while ($fgets(line, trace_fd) != 0) begin
         line_no++;
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         fields = $sscanf(line, "%d %d %h %d %d %d %d %d %h", cnt, w_en, w_data,
                          r_en, e_empty, e_full, e_level, e_chk, e_rdata);
         if (fields != 9 || cnt < 1) begin
            abort_run($sformatf("malformed trace record on line %0d", line_no));
         end
         // write data counts up over the cycles of one record
         for (int k = 0; k < cnt; k++) begin
            @(posedge clk_i);
            w_en_i   <= w_en[0];
            w_data_i <= W_DATA_W'(w_data + k);
            r_en_i   <= r_en[0];
            @(negedge clk_i);
            if (k == 0) begin
               check_pending();
            end
         end
         have_pending = 1'b1;
         p_line       = line_no;
         p_empty      = e_empty;
         p_full       = e_full;
         p_level      = e_level;
         p_chk        = e_chk;
         p_rdata      = e_rdata;
         records++;
      end
      $fclose(trace_fd);

      // one idle cycle so the last record gets sampled
      @(posedge clk_i);
      w_en_i <= 1'b0;
      r_en_i <= 1'b0;
      @(negedge clk_i);
      check_pending();
      wait_drained();

      if (records == 0) begin
         $display("the trace file held no records");
         $display("TEST RESULT: FAIL");
         $fatal(1, "empty trace");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

/* tb/fifo_trace.txt */
# cnt w_en w_data(hex) r_en | empty full level chk r_data(hex) expected after the last cycle
# a record repeats its controls for cnt cycles, w_data counting up by one per cycle
1 0 00 0 1 0 0 1 00000000
1 0 00 1 1 0 0 1 00000000
1 1 11 0 1 0 1 0 00000000
1 1 12 0 1 0 2 0 00000000
1 1 13 0 1 0 3 0 00000000
1 1 14 0 0 0 4 0 00000000
1 0 00 1 1 0 0 1 14131211
3 1 21 0 1 0 3 0 00000000
1 0 00 1 1 0 3 1 14131211
60 1 24 0 0 0 63 0 00000000
1 1 60 0 0 1 64 0 00000000
1 1 ee 0 0 1 64 0 00000000
1 0 00 1 0 0 60 1 24232221
1 0 00 1 0 0 56 1 28272625
1 0 00 1 0 0 52 1 2c2b2a29
1 0 00 1 0 0 48 1 302f2e2d
1 0 00 1 0 0 44 1 34333231
1 0 00 1 0 0 40 1 38373635
1 0 00 1 0 0 36 1 3c3b3a39
1 0 00 1 0 0 32 1 403f3e3d
1 0 00 1 0 0 28 1 44434241
1 0 00 1 0 0 24 1 48474645
1 0 00 1 0 0 20 1 4c4b4a49
1 0 00 1 0 0 16 1 504f4e4d
1 0 00 1 0 0 12 1 54535251
1 0 00 1 0 0 8 1 58575655
1 0 00 1 0 0 4 1 5c5b5a59
1 0 00 1 1 0 0 1 605f5e5d
1 1 71 1 1 0 1 1 605f5e5d
3 1 72 1 0 0 4 1 605f5e5d
1 1 75 1 1 0 1 1 74737271
3 1 76 1 0 0 4 1 74737271
1 1 79 1 1 0 1 1 78777675
3 1 7a 0 0 0 4 0 00000000
1 0 00 1 1 0 0 1 7c7b7a79

/* compile.f */
rtl/fifo_pkg.sv
rtl/fifo_ctrl.sv
rtl/fifo_addr_gen.sv
rtl/fifo_asym_converter.sv
rtl/fifo_ram_2p.sv
rtl/fifo_sync_top.sv
tb/fifo_sync_sva.sv
tb/fifo_sync_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module fifo_sync_tb \
   -Mdir obj_dir -o fifo_sync_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/fifo_sync_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "^TEST RESULT: PASS$"; then
   exit 0
fi

echo "pass line not found in the simulation output"
exit 1
